//--- merge_pkg.sv
package merge_pkg;

    // Merge fan-in and the index that walks it
    localparam int NUM_IN = 16;
    localparam int SEL_W  = 4;

    // Configuration port address width
    localparam int CFG_ADDR_W = 5;

    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

    // Register map
    //   0 .. NUM_IN-1   data words
    //   ADDR_DELAY      start delay in cycles
    //   ADDR_RUN        run command, write only, reads as zero
    localparam cfg_addr_t ADDR_DELAY = cfg_addr_t'(16);
    localparam cfg_addr_t ADDR_RUN   = cfg_addr_t'(17);

endpackage

//--- merge_cfg_if.sv
interface merge_cfg_if #(
    parameter int DATA_W  = 32,
    parameter int DELAY_W = 32
);
    import merge_pkg::*;

    logic [DATA_W-1:0]  words [NUM_IN]; // One word per merge input
    logic [DELAY_W-1:0] delay;          // Cycles to wait after run
    logic               run;            // Single cycle start strobe

    // Register bank side
    modport cfg (
        output words,
        output delay,
        output run
    );

    // Merge unit side
    modport unit (
        input words,
        input delay,
        input run
    );

endinterface

//--- merge_cfg.sv
module merge_cfg #(
    parameter int DATA_W  = 32,
    parameter int DELAY_W = 32
) (
    input  logic                clk,
    input  logic                rst,

    // Four-phase host port
    input  logic                cfg_req,
    input  logic                cfg_we,
    input  merge_pkg::cfg_addr_t cfg_addr,
    input  logic [DATA_W-1:0]   cfg_wdata,
    output logic                cfg_ack,
    output logic [DATA_W-1:0]   cfg_rdata,

    // Towards the merge unit
    merge_cfg_if.cfg            cfg
);
    import merge_pkg::*;

    logic [DATA_W-1:0]  words_q [NUM_IN];
    logic [DELAY_W-1:0] delay_q;
    logic               run_q;

    logic               access;
    logic               wr_en;
    logic               rd_en;
    logic [DATA_W-1:0]  rd_word;

    // New request accepted only while ack is still low
    assign access = cfg_req && !cfg_ack;
    assign wr_en  = access && cfg_we;
    assign rd_en  = access && !cfg_we;

    // Ack rises on the access edge and stays up until req has gone
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_ack <= 1'b0;
        end else if (access) begin
            cfg_ack <= 1'b1;
        end else if (!cfg_req) begin
            cfg_ack <= 1'b0;
        end
    end

    // Data words
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_IN; i++) begin
                words_q[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 0; i < NUM_IN; i++) begin
                if (cfg_addr == cfg_addr_t'(i)) begin
                    words_q[i] <= cfg_wdata;
                end
            end
        end
    end

    // Start delay
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            delay_q <= '0;
        end else if (wr_en && (cfg_addr == ADDR_DELAY)) begin
            delay_q <= DELAY_W'(cfg_wdata);
        end
    end

    // Run strobe, high for the one cycle after the write edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= wr_en && (cfg_addr == ADDR_RUN);
        end
    end

    // Readback decode
    always_comb begin
        rd_word = '0; // Run and unmapped addresses
        for (int i = 0; i < NUM_IN; i++) begin
            if (cfg_addr == cfg_addr_t'(i)) begin
                rd_word = words_q[i];
            end
        end
        if (cfg_addr == ADDR_DELAY) begin
            rd_word = DATA_W'(delay_q);
        end
    end

    // Read data captured together with the ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg_rdata <= '0;
        end else if (rd_en) begin
            cfg_rdata <= rd_word;
        end
    end

    assign cfg.words = words_q;
    assign cfg.delay = delay_q;
    assign cfg.run   = run_q;

endmodule

//--- merge_unit.sv
module merge_unit #(
    parameter int DATA_W  = 32,
    parameter int DELAY_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    merge_cfg_if.unit         cfg,
    output logic [DATA_W-1:0] merge_out
);
    import merge_pkg::*;

    logic [DELAY_W-1:0] delay_q;  // Remaining start delay
    logic [SEL_W-1:0]   sel_q;    // Input currently routed to the output
    logic               armed_q;  // Set by the first run
    logic [DATA_W-1:0]  sel_word;

    assign sel_word = cfg.words[sel_q];

    // Delay countdown and input index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            delay_q <= '0;
            sel_q   <= '0;
            armed_q <= 1'b0;
        end else if (cfg.run) begin
            delay_q <= cfg.delay; // Restart from input 0
            sel_q   <= '0;
            armed_q <= 1'b1;
        end else if (delay_q != '0) begin
            delay_q <= delay_q - 1'b1;
        end else if (armed_q) begin
            // Step one input per cycle, back to 0 after the last
            if (sel_q == SEL_W'(NUM_IN - 1)) begin
                sel_q <= '0;
            end else begin
                sel_q <= sel_q + 1'b1;
            end
        end
    end

    // Registered selector, holds on the run edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            merge_out <= '0;
        end else if (!cfg.run) begin
            merge_out <= sel_word;
        end
    end

endmodule

//--- merge_top.sv
module merge_top #(
    parameter int DATA_W  = 32,
    parameter int DELAY_W = 32
) (
    input  logic                            clk,
    input  logic                            rst,

    // Configuration port, four-phase req/ack
    input  logic                            cfg_req,
    input  logic                            cfg_we,
    input  logic [merge_pkg::CFG_ADDR_W-1:0] cfg_addr,
    input  logic [DATA_W-1:0]               cfg_wdata,
    output logic                            cfg_ack,
    output logic [DATA_W-1:0]               cfg_rdata,

    // Merged stream
    output logic [DATA_W-1:0]               merge_out
);
    import merge_pkg::*;

    merge_cfg_if #(
        .DATA_W  (DATA_W),
        .DELAY_W (DELAY_W)
    ) cfg_bus ();

    merge_cfg #(
        .DATA_W  (DATA_W),
        .DELAY_W (DELAY_W)
    ) i_merge_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_req   (cfg_req),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr_t'(cfg_addr)),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg_bus.cfg)
    );

    merge_unit #(
        .DATA_W  (DATA_W),
        .DELAY_W (DELAY_W)
    ) i_merge_unit (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg_bus.unit),
        .merge_out (merge_out)
    );

endmodule

//--- merge_top_assert.sv
module merge_top_assert (
    input logic clk,
    input logic rst,
    input logic cfg_req,
    input logic cfg_ack,
    input logic run
);

    // Ack only answers a pending request
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(cfg_ack) |-> $past(cfg_req)
    ) else $error("cfg_ack rose while cfg_req was low");

    run_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        run |=> !run
    ) else $error("run strobe stayed high for more than one cycle");

    // Ack release follows the host dropping req
    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (rst)
        $fell(cfg_ack) |-> !$past(cfg_req)
    ) else $error("cfg_ack fell while cfg_req was still high");

endmodule

bind merge_cfg merge_top_assert i_merge_top_assert (
    .clk     (clk),
    .rst     (rst),
    .cfg_req (cfg_req),
    .cfg_ack (cfg_ack),
    .run     (run_q)
);

//--- merge_top_tb.sv
module merge_top_tb;
    import merge_pkg::*;

    localparam int DATA_W       = 32;
    localparam int DELAY_W      = 32;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 6;

    localparam int MODE_COUNT  = 0;
    localparam int MODE_LFSR   = 1;
    localparam int ACT_NONE    = 0;
    localparam int ACT_RESTART = 1; // Second run in the middle of the sequence
    localparam int ACT_LIVE    = 2; // Word writes while the run is going

    // Test table, one column per entry
    localparam int TEST_DELAY  [NUM_TESTS] = '{0, 1, 5, 20, 2, 0};
    localparam int TEST_MODE   [NUM_TESTS] = '{MODE_COUNT, MODE_COUNT, MODE_LFSR,
                                               MODE_COUNT, MODE_LFSR, MODE_LFSR};
    localparam int TEST_CYCLES [NUM_TESTS] = '{48, 32, 40, 52, 48, 48};
    localparam int TEST_ACTION [NUM_TESTS] = '{ACT_NONE, ACT_NONE, ACT_NONE,
                                               ACT_NONE, ACT_RESTART, ACT_LIVE};
    string test_name [NUM_TESTS] = '{"zero_delay", "delay_1", "delay_5",
                                     "delay_20", "restart", "live_update"};

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  cfg_req;
    logic                  cfg_we;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    logic [DATA_W-1:0]     cfg_wdata;
    logic                  cfg_ack;
    logic [DATA_W-1:0]     cfg_rdata;
    logic [DATA_W-1:0]     merge_out;

    // Host side copy of the register bank
    logic [DATA_W-1:0]  model_words [NUM_IN];
    logic [DELAY_W-1:0] model_delay;
    int                 run_ack_edge; // Edge at which the last run write was acked
    int                 run_delay;    // Delay that run started with

    int          edge_cnt = 0;
    logic [31:0] lfsr_state;
    int          test_errors;
    int          error_count = 0;
    int          check_count = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;

    merge_top #(
        .DATA_W  (DATA_W),
        .DELAY_W (DELAY_W)
    ) i_merge_top (
        .clk       (clk),
        .rst       (rst),
        .cfg_req   (cfg_req),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata),
        .merge_out (merge_out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic random_word(output logic [DATA_W-1:0] word);
        word = '0;
        for (int b = 0; b < DATA_W; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word = {word[DATA_W-2:0], lfsr_state[0]};
        end
    endtask

    // Word on merge_out after edge E_i of a run with delay d
    function automatic int expected_slot(input int i, input int d);
        if (i - 1 < d) begin
            return 0;
        end
        return (i - 1 - d) % NUM_IN;
    endfunction

    function automatic int watchdog_cycles();
        int sum;
        sum = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            sum += TEST_CYCLES[t];
        end
        return sum * 4 + RESET_CYCLES;
    endfunction

    task automatic update_model(input int addr, input logic [DATA_W-1:0] data, input int ack);
        if (addr < NUM_IN) begin
            model_words[addr] = data;
        end else if (addr == int'(ADDR_DELAY)) begin
            model_delay = DELAY_W'(data);
        end else if (addr == int'(ADDR_RUN)) begin
            run_ack_edge = ack;
            run_delay    = int'(model_delay);
        end
    endtask

    // One four-phase transfer, returns once ack is low again
    task automatic cfg_access(input logic we, input int addr, input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata);
        int ack_edge;
        @(posedge clk);
        cfg_req   <= 1'b1;
        cfg_we    <= we;
        cfg_addr  <= CFG_ADDR_W'(addr);
        cfg_wdata <= wdata;
        @(negedge clk);
        while (!cfg_ack) begin
            @(negedge clk);
        end
        ack_edge = edge_cnt;
        rdata    = cfg_rdata;
        @(posedge clk);
        cfg_req <= 1'b0;
        if (we) begin
            update_model(addr, wdata, ack_edge); // Bank changed at the ack edge
        end
        @(negedge clk);
        while (cfg_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic cfg_write(input int addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        cfg_access(1'b1, addr, data, unused);
    endtask

    task automatic cfg_read(input int addr, output logic [DATA_W-1:0] data);
        cfg_access(1'b0, addr, '0, data);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        error_count += test_errors;
        if (test_errors == 0) begin
            pass_count++;
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
            $display("[FAIL] %s: %0d mismatches", name, test_errors);
        end
    endtask

    // Sampled before any clock edge without reset
    task automatic check_reset();
        test_errors = 0;
        @(negedge clk);
        check_value("reset merge_out", '0, merge_out);
        check_value("reset cfg_ack", '0, DATA_W'(cfg_ack));
        finish_test("reset");
    endtask

    task automatic check_readback();
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] rd;
        test_errors = 0;
        for (int k = 0; k < NUM_IN; k++) begin
            random_word(w);
            cfg_write(k, w);
        end
        random_word(w);
        cfg_write(ADDR_DELAY, w);
        for (int k = 0; k < NUM_IN; k++) begin
            cfg_read(k, rd);
            check_value($sformatf("readback word %0d", k), model_words[k], rd);
        end
        cfg_read(ADDR_DELAY, rd);
        check_value("readback delay", DATA_W'(model_delay), rd);
        cfg_read(ADDR_RUN, rd);
        check_value("readback run", '0, rd);
        // No run yet, so the index is still parked at input 0
        check_value("idle merge_out", model_words[0], merge_out);
        finish_test("readback");
    endtask

    // Compare merge_out once per cycle against the E_i rule
    task automatic check_cycles(input string name, input int cycles);
        int i;
        repeat (cycles) begin
            i = edge_cnt - run_ack_edge - 1;
            if (i >= 1) begin // Output holds at E0
                check_value($sformatf("%s E%0d", name, i),
                            model_words[expected_slot(i, run_delay)], merge_out);
            end
            @(negedge clk);
        end
    endtask

    task automatic mid_run_action(input int action);
        logic [DATA_W-1:0] w;
        case (action)
            ACT_RESTART: begin
                repeat (10) @(negedge clk);
                cfg_write(ADDR_DELAY, 3);
                cfg_write(ADDR_RUN, 0);
            end
            ACT_LIVE: begin
                repeat (6) @(negedge clk);
                random_word(w);
                cfg_write(12, w); // Still ahead of the index
                random_word(w);
                cfg_write(3, w);  // Shows after the wrap
            end
            default: begin
            end
        endcase
    endtask

    task automatic run_test(input int t);
        logic [DATA_W-1:0] w;
        test_errors = 0;
        for (int k = 0; k < NUM_IN; k++) begin
            if (TEST_MODE[t] == MODE_COUNT) begin
                w = DATA_W'(32'h1000 + k);
            end else begin
                random_word(w);
            end
            cfg_write(k, w);
        end
        cfg_write(ADDR_DELAY, DATA_W'(TEST_DELAY[t]));
        cfg_write(ADDR_RUN, 0);
        fork
            check_cycles(test_name[t], TEST_CYCLES[t]);
            mid_run_action(TEST_ACTION[t]);
        join
        finish_test(test_name[t]);
    endtask

    initial begin
        int limit;
        limit = watchdog_cycles() * 10;
        #(limit);
        $display("Simulation timed out before all tests completed");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst       <= 1'b1;
        cfg_req   <= 1'b0;
        cfg_we    <= 1'b0;
        cfg_addr  <= '0;
        cfg_wdata <= '0;
        for (int k = 0; k < NUM_IN; k++) begin
            model_words[k] = '0;
        end
        model_delay  = '0;
        run_ack_edge = 0;
        run_delay    = 0;
        lfsr_state   = 32'hbbd335e2;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        check_reset();
        check_readback();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 pass_count, fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- merge_top.f
merge_pkg.sv
merge_cfg_if.sv
merge_cfg.sv
merge_unit.sv
merge_top.sv
merge_top_assert.sv
merge_top_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module merge_top_tb \
    -f merge_top.f -o merge_top_sim || exit 1
out=$(./obj_dir/merge_top_sim)
echo "$out"
echo "$out" | grep -q "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
